// ==== hw/hv_pkg.sv ====
`default_nettype none

package hv_pkg;

    // hypervector dimensions
    localparam int DIM = 1024;

    // encoder cores feeding the bundler
    localparam int CORE_NUM = 8;

    // per-dimension vote counter width
    // far more headroom than any realistic run needs
    localparam int CNT_W = 26;

    // output beat width
    localparam int STREAM_W = 512;

    // beats per read-out, low half first
    localparam int BEATS = DIM / STREAM_W;

    // index of one beat inside a read-out
    localparam int BEAT_IDX_W = (BEATS > 1) ? $clog2(BEATS) : 1;

    // width holding 0..CORE_NUM votes in one cycle
    localparam int VOTE_CNT_W = $clog2(CORE_NUM + 1);

    // bipolar hypervector
    // bit 1 is +1, bit 0 is -1
    typedef logic [DIM-1:0] hv_t;

    // all core vectors, core 0 in slot 0
    typedef hv_t [CORE_NUM-1:0] core_hv_t;

    // command opcodes
    typedef enum logic [1:0] {
        OP_ACCUM = 2'd0,
        OP_CLEAR = 2'd1,
        OP_READ  = 2'd2
    } cmd_op_t;

    // one command strobe
    // valid for a single cycle, never refused
    typedef struct packed {
        logic                valid;
        cmd_op_t             op;
        logic [CORE_NUM-1:0] store_mask;
    } cmd_t;

    // read-out FSM states
    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_LO   = 2'd1,
        ST_HI   = 2'd2
    } seq_state_t;

    // sequencer to buffer
    // stream_v picks a half, last_stream marks the upper one
    typedef struct packed {
        logic stream_v;
        logic last_stream;
    } stream_ctrl_t;

    // output beat, no back-pressure
    typedef struct packed {
        logic                valid;
        logic                last;
        logic [STREAM_W-1:0] data;
    } beat_t;

endpackage

`default_nettype wire

// ==== hw/dim_counter.sv ====
`default_nettype none

module dim_counter (
    input  wire                         clk,
    input  wire                         arst_n,
    // zero the count
    input  wire                         clear,
    // cores whose vote counts this cycle
    input  wire  [hv_pkg::CORE_NUM-1:0] accum_mask,
    // one bit per core at this dimension, core 0 at bit 0
    input  wire  [hv_pkg::CORE_NUM-1:0] votes,
    // count strictly positive
    output logic                        sign_bit
);

    // running signed vote total
    logic signed [hv_pkg::CNT_W-1:0]    count;

    // masked votes for +1 and -1
    logic [hv_pkg::VOTE_CNT_W-1:0]      n_up;
    logic [hv_pkg::VOTE_CNT_W-1:0]      n_dn;

    // counts widened to the counter
    logic signed [hv_pkg::CNT_W-1:0]    up_ext;
    logic signed [hv_pkg::CNT_W-1:0]    dn_ext;
    logic signed [hv_pkg::CNT_W-1:0]    delta;

    // popcount of the masked votes
    always_comb begin
        n_up = '0;
        n_dn = '0;
        for (int c = 0; c < hv_pkg::CORE_NUM; c++) begin
            if (accum_mask[c]) begin
                if (votes[c]) begin
                    n_up = n_up + 1'b1;
                end else begin
                    n_dn = n_dn + 1'b1;
                end
            end
        end
    end

    // zero extend, both are non-negative
    assign up_ext = $signed({{(hv_pkg::CNT_W - hv_pkg::VOTE_CNT_W){1'b0}}, n_up});
    assign dn_ext = $signed({{(hv_pkg::CNT_W - hv_pkg::VOTE_CNT_W){1'b0}}, n_dn});

    // net change this cycle
    assign delta = up_ext - dn_ext;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (|accum_mask) begin
            // no saturation
            count <= count + delta;
        end
    end

    // positive means sign clear and not zero
    // a tie reads as 0
    assign sign_bit = ~count[hv_pkg::CNT_W-1] & (|count);

endmodule

`default_nettype wire

// ==== hw/bundle_buffer.sv ====
`default_nettype none

module bundle_buffer (
    input  wire                          clk,
    input  wire                          arst_n,
    // one-cycle zero of every counter
    input  wire                          clear,
    // masked cores for this cycle, zero when idle
    input  wire  [hv_pkg::CORE_NUM-1:0]  accum_mask,
    // all core vectors, core 0 in slot 0
    input  wire  hv_pkg::core_hv_t       core_hv,
    // half select from the sequencer
    input  wire  hv_pkg::stream_ctrl_t   ctrl,
    // registered beat word
    output logic [hv_pkg::STREAM_W-1:0]  stream_d,
    // live sign vector
    output wire  hv_pkg::hv_t            sign_vec
);

    // half index for the part select
    logic [hv_pkg::BEAT_IDX_W-1:0] half_sel;

    // one counter per dimension
    for (genvar i = 0; i < hv_pkg::DIM; i++) begin : g_dim

        // bit i of every core
        // core 0 ends up at the lowest position
        wire [hv_pkg::CORE_NUM-1:0] votes;

        for (genvar c = 0; c < hv_pkg::CORE_NUM; c++) begin : g_core
            assign votes[c] = core_hv[c][i];
        end

        dim_counter u_cnt (
            .clk        (clk),
            .arst_n     (arst_n),
            .clear      (clear),
            .accum_mask (accum_mask),
            .votes      (votes),
            .sign_bit   (sign_vec[i])
        );

    end

    // upper half on the last beat
    assign half_sel = ctrl.last_stream ? hv_pkg::BEAT_IDX_W'(hv_pkg::BEATS - 1)
                                       : '0;

    // snapshot the sign vector in the stream_v cycle
    // the beat shows up one cycle later
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stream_d <= '0;
        end else if (ctrl.stream_v) begin
            stream_d <= sign_vec[half_sel * hv_pkg::STREAM_W +: hv_pkg::STREAM_W];
        end
    end

endmodule

`default_nettype wire

// ==== hw/stream_sequencer.sv ====
`default_nettype none

module stream_sequencer (
    input  wire                          clk,
    input  wire                          arst_n,
    // command strobe, one cycle each
    input  wire  hv_pkg::cmd_t           cmd,
    // store mask, only on an accumulate
    output logic [hv_pkg::CORE_NUM-1:0]  accum_mask,
    // counter clear pulse
    output logic                         clear,
    // half select to the buffer
    output hv_pkg::stream_ctrl_t         ctrl,
    // beat strobes, one cycle behind ctrl
    output logic                         beat_v,
    output logic                         beat_last
);

    hv_pkg::seq_state_t state;
    hv_pkg::seq_state_t state_nxt;

    // decoded strobes
    logic is_accum;
    logic is_clear;
    logic is_read;

    // opcode decode
    always_comb begin
        is_accum = 1'b0;
        is_clear = 1'b0;
        is_read  = 1'b0;
        if (cmd.valid) begin
            case (cmd.op)
                hv_pkg::OP_ACCUM: is_accum = 1'b1;
                hv_pkg::OP_CLEAR: is_clear = 1'b1;
                hv_pkg::OP_READ:  is_read  = 1'b1;
                default: ;
            endcase
        end
    end

    // counters act at the edge closing this cycle
    assign accum_mask = is_accum ? cmd.store_mask : '0;
    assign clear      = is_clear;

    // read-out walk
    always_comb begin
        state_nxt = state;
        case (state)
            hv_pkg::ST_IDLE: begin
                if (is_read) begin
                    state_nxt = hv_pkg::ST_LO;
                end
            end
            // reads here are dropped
            hv_pkg::ST_LO: state_nxt = hv_pkg::ST_HI;
            hv_pkg::ST_HI: state_nxt = hv_pkg::ST_IDLE;
            default:       state_nxt = hv_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= hv_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // stream_v in both busy states
    assign ctrl.stream_v    = (state == hv_pkg::ST_LO) || (state == hv_pkg::ST_HI);
    assign ctrl.last_stream = (state == hv_pkg::ST_HI);

    // buffer registers the word, so the strobes follow a cycle later
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            beat_v    <= 1'b0;
            beat_last <= 1'b0;
        end else begin
            beat_v    <= ctrl.stream_v;
            beat_last <= ctrl.last_stream;
        end
    end

endmodule

`default_nettype wire

// ==== hw/hv_bundle_top.sv ====
`default_nettype none

module hv_bundle_top (
    input  wire                     clk,
    input  wire                     arst_n,
    // command strobe, never refused
    input  wire  hv_pkg::cmd_t      cmd,
    // sampled with an accumulate
    input  wire  hv_pkg::core_hv_t  core_hv,
    // output beat stream
    output wire  hv_pkg::beat_t     beat,
    // sign vector for observation
    output wire  hv_pkg::hv_t       sign_vec
);

    // sequencer to buffer
    wire [hv_pkg::CORE_NUM-1:0] accum_mask;
    wire                        clear;
    hv_pkg::stream_ctrl_t       ctrl;

    // beat pieces
    wire [hv_pkg::STREAM_W-1:0] stream_d;
    wire                        beat_v;
    wire                        beat_last;

    // command decode and read-out FSM
    stream_sequencer u_seq (
        .clk        (clk),
        .arst_n     (arst_n),
        .cmd        (cmd),
        .accum_mask (accum_mask),
        .clear      (clear),
        .ctrl       (ctrl),
        .beat_v     (beat_v),
        .beat_last  (beat_last)
    );

    // counters and beat word
    bundle_buffer u_buf (
        .clk        (clk),
        .arst_n     (arst_n),
        .clear      (clear),
        .accum_mask (accum_mask),
        .core_hv    (core_hv),
        .ctrl       (ctrl),
        .stream_d   (stream_d),
        .sign_vec   (sign_vec)
    );

    // pack the beat
    assign beat = hv_pkg::beat_t'{
        valid: beat_v,
        last:  beat_last,
        data:  stream_d
    };

endmodule

`default_nettype wire

// ==== bench/hv_bundle_checker.sv ====
`default_nettype none

module hv_bundle_checker (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire  hv_pkg::cmd_t     cmd,
    input  wire  hv_pkg::core_hv_t core_hv,
    input  wire  hv_pkg::beat_t    beat,
    // mismatches and protocol faults so far
    output int                     errors,
    // beats seen on the output
    output int                     beats
);

    timeunit 1ns;
    timeprecision 1ps;

    // reads the model accepted
    int reads;

    // model vote count per dimension
    int cnt [hv_pkg::DIM];

    // model fsm
    // 0 idle, 1 snapshots the low half, 2 the high half
    int phase;

    // beat due in the current cycle
    logic                        exp_v;
    logic                        exp_last;
    logic [hv_pkg::STREAM_W-1:0] exp_data;
    int                          exp_idx;

    // beats seen for the read in flight
    int rd_beats;

    // expected half of the majority vector
    function automatic logic [hv_pkg::STREAM_W-1:0] ref_half(
        input int counts [hv_pkg::DIM],
        input int idx
    );
        logic [hv_pkg::STREAM_W-1:0] h;
        h = '0;
        for (int b = 0; b < hv_pkg::STREAM_W; b++) begin
            // strictly positive wins
            // a tie reads as 0
            h[b] = (counts[idx * hv_pkg::STREAM_W + b] > 0);
        end
        return h;
    endfunction

    // compare what the DUT presents against the scheduled beat
    task automatic check_beat();
        if (beat.valid) begin
            beats = beats + 1;
        end
        if (exp_v) begin
            if (!beat.valid) begin
                $display("beat %0d of read %0d did not arrive at its fixed latency (%0d ns)",
                         exp_idx, reads, $time);
                errors++;
            end else begin
                if (beat.last !== exp_last) begin
                    $display("Error at %0d ns: beat %0d has last flag %0b", $time, exp_idx,
                             beat.last);
                    errors++;
                end
                if (beat.data !== exp_data) begin
                    $display("Error at %0d ns: beat %0d data mismatch", $time, exp_idx);
                    errors++;
                end
            end
            rd_beats = (exp_idx == 0) ? int'(beat.valid) : rd_beats + int'(beat.valid);
            if (exp_last && rd_beats != hv_pkg::BEATS) begin
                $display("read %0d produced %0d beats instead of two", reads, rd_beats);
                errors++;
            end
        end else if (beat.valid) begin
            $display("a beat appeared at %0d ns with no read pending", $time);
            errors++;
        end
    endtask

    // accumulate and clear rules on the model counts
    task automatic apply_cmd();
        if (cmd.valid && cmd.op == hv_pkg::OP_CLEAR) begin
            for (int d = 0; d < hv_pkg::DIM; d++) begin
                cnt[d] = 0;
            end
        end else if (cmd.valid && cmd.op == hv_pkg::OP_ACCUM) begin
            for (int d = 0; d < hv_pkg::DIM; d++) begin
                for (int c = 0; c < hv_pkg::CORE_NUM; c++) begin
                    if (cmd.store_mask[c]) begin
                        cnt[d] = cnt[d] + (core_hv[c][d] ? 1 : -1);
                    end
                end
            end
        end
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int d = 0; d < hv_pkg::DIM; d++) begin
                cnt[d] = 0;
            end
            phase    = 0;
            exp_v    = 1'b0;
            exp_last = 1'b0;
            exp_data = '0;
            exp_idx  = 0;
            rd_beats = 0;
            errors   = 0;
            beats    = 0;
            reads    = 0;
        end else begin
            check_beat();
            // snapshot before this cycle's votes land
            exp_v    = (phase != 0);
            exp_last = (phase == 2);
            exp_idx  = (phase == 2) ? 1 : 0;
            if (phase != 0) begin
                exp_data = ref_half(cnt, exp_idx);
            end
            apply_cmd();
            // reads while busy are dropped
            if (phase == 1) begin
                phase = 2;
            end else if (phase == 2) begin
                phase = 0;
            end else if (cmd.valid && cmd.op == hv_pkg::OP_READ) begin
                phase = 1;
                reads++;
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/tb_hv_bundle.sv ====
`default_nettype none

module tb_hv_bundle;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          CLK_PERIOD = 8;
    localparam int          RST_CYCLES = 3;
    localparam logic [31:0] SEED       = 32'h661d_949a;

    // commands per test
    // the watchdog scales with their sum
    localparam int N_MIX   = 40;
    localparam int N_PRE   = 12;
    localparam int N_POST  = 9;
    localparam int N_CMDS  = 1 + 2 + (N_MIX + 1) + (N_PRE + 1 + N_POST + 1) + 2 + 3;
    localparam int WDOG_NS = (N_CMDS * 10 + RST_CYCLES + 100) * CLK_PERIOD;

    logic             clk;
    logic             arst_n;
    hv_pkg::cmd_t     cmd;
    hv_pkg::core_hv_t core_hv;
    hv_pkg::beat_t    beat;
    hv_pkg::hv_t      sign_vec;

    int chk_errors;
    int chk_beats;
    int tb_errors;
    int tests_ok;
    int tests_bad;
    int err_mark;
    int base;

    hv_bundle_top UUT (
        .clk      (clk),
        .arst_n   (arst_n),
        .cmd      (cmd),
        .core_hv  (core_hv),
        .beat     (beat),
        .sign_vec (sign_vec)
    );

    hv_bundle_checker u_chk (
        .clk     (clk),
        .arst_n  (arst_n),
        .cmd     (cmd),
        .core_hv (core_hv),
        .beat    (beat),
        .errors  (chk_errors),
        .beats   (chk_beats)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // hang guard
    initial begin
        #(WDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WDOG_NS);
        $display("sim failed");
        $finish;
    end

    // random hypervectors for all cores
    // filled 32 bits at a time
    function automatic hv_pkg::core_hv_t rand_cores();
        hv_pkg::core_hv_t cv;
        for (int c = 0; c < hv_pkg::CORE_NUM; c++) begin
            for (int w = 0; w < hv_pkg::DIM / 32; w++) begin
                cv[c][w*32 +: 32] = $urandom();
            end
        end
        return cv;
    endfunction

    // one command strobe on the next falling edge
    task automatic send_cmd(input hv_pkg::cmd_op_t op,
                            input logic [hv_pkg::CORE_NUM-1:0] mask,
                            input hv_pkg::core_hv_t hv);
        @(negedge clk);
        cmd.valid      = 1'b1;
        cmd.op         = op;
        cmd.store_mask = mask;
        core_hv        = hv;
    endtask

    // drop the strobe, then idle n more cycles
    task automatic idle(input int n);
        @(negedge clk);
        cmd.valid      = 1'b0;
        cmd.store_mask = '0;
        repeat (n) @(negedge clk);
    endtask

    task automatic accum_random(input int n);
        for (int i = 0; i < n; i++) begin
            send_cmd(hv_pkg::OP_ACCUM, hv_pkg::CORE_NUM'($urandom()), rand_cores());
        end
        idle(0);
    endtask

    // read and wait for both beats within a bound
    task automatic read_out();
        int start;
        int waited;
        start  = chk_beats;
        waited = 0;
        send_cmd(hv_pkg::OP_READ, '0, core_hv);
        idle(0);
        while (chk_beats < start + hv_pkg::BEATS && waited < 8) begin
            @(negedge clk);
            waited++;
        end
        if (chk_beats < start + hv_pkg::BEATS) begin
            $display("read near %0d ns never delivered both beats", $time);
            tb_errors++;
        end
        idle(1);
    endtask

    task automatic check_sign(input hv_pkg::hv_t expected, input string what);
        if (sign_vec !== expected) begin
            $display("Error at %0d ns: sign vector %s mismatch", $time, what);
            tb_errors++;
        end
    endtask

    task automatic check_beat_count(input int start, input string what);
        if (chk_beats != start + hv_pkg::BEATS) begin
            $display("%s gave %0d beats where two were due", what, chk_beats - start);
            tb_errors++;
        end
    endtask

    // one line per test
    task automatic finish_test(input string name);
        int n;
        n = chk_errors + tb_errors - err_mark;
        if (n == 0) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, n);
        end
        err_mark = chk_errors + tb_errors;
    endtask

    initial begin
        hv_pkg::core_hv_t v;
        void'($urandom(SEED));
        cmd       = '0;
        core_hv   = '0;
        arst_n    = 1'b0;
        tb_errors = 0;
        tests_ok  = 0;
        tests_bad = 0;
        err_mark  = 0;
        repeat (RST_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        // zero counts read as all zeros
        read_out();
        finish_test("reset");

        // only core 0 voting
        v = rand_cores();
        send_cmd(hv_pkg::OP_ACCUM, 8'h01, v);
        idle(0);
        check_sign(v[0], "after single core");
        read_out();
        finish_test("single_core");

        // random masks with ties included
        accum_random(N_MIX);
        read_out();
        finish_test("mixed_masks");

        accum_random(N_PRE);
        send_cmd(hv_pkg::OP_CLEAR, '0, core_hv);
        idle(0);
        check_sign('0, "after clear");
        accum_random(N_POST);
        read_out();
        finish_test("clear");

        // second read lands in ST_LO and is dropped
        base = chk_beats;
        send_cmd(hv_pkg::OP_READ, '0, core_hv);
        send_cmd(hv_pkg::OP_READ, '0, core_hv);
        idle(6);
        check_beat_count(base, "read pair");
        finish_test("dropped_read");

        // accumulate right before the read and during ST_LO
        base = chk_beats;
        send_cmd(hv_pkg::OP_ACCUM, 8'hff, rand_cores());
        send_cmd(hv_pkg::OP_READ, '0, core_hv);
        send_cmd(hv_pkg::OP_ACCUM, 8'hff, rand_cores());
        idle(6);
        check_beat_count(base, "back-to-back read");
        finish_test("back_to_back");

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_ok, tests_bad, chk_errors + tb_errors);
        if (tests_bad == 0 && chk_errors + tb_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
hw/hv_pkg.sv
hw/dim_counter.sv
hw/bundle_buffer.sv
hw/stream_sequencer.sv
hw/hv_bundle_top.sv
bench/hv_bundle_checker.sv
bench/tb_hv_bundle.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     := --binary --timing -Wno-fatal -j 0
TOP       := tb_hv_bundle
FILELIST  := sim.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := sim passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
